// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINT      = --lint-only --timing -Wall
TOP       = tb_shifter_host
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
SOURCES   = $(wildcard hw/*.sv test/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: flist.f
hw/shifter_pkg.sv
hw/shift_stepper.sv
hw/rotate_datapath.sv
hw/trojan_trigger.sv
hw/shifter_host_top.sv
test/tb_shifter_host_sva.sv
test/tb_shifter_host.sv

// File: hw/rotate_datapath.sv
// ----------------------------------------------------------
// Rotate datapath
// Loads and rotates the word and registers the masked output
// ----------------------------------------------------------
`timescale 1ns/1ps

module rotate_datapath (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [shifter_pkg::data_width-1:0] data_in,
    input  logic                              load_data,
    input  logic                              shifting,
    input  logic                              last_step,
    input  shifter_pkg::shift_dir_e           shift_dir,
    input  logic                              trigger,
    output logic [shifter_pkg::data_width-1:0] data_out,
    output logic                              shift_complete
);

    import shifter_pkg::*;

    logic [data_width-1:0] shift_reg;
    logic [data_width-1:0] rot_left;
    logic [data_width-1:0] rot_right;
    logic [data_width-1:0] rot_next;
    logic [data_width-1:0] out_mask;

    // Single-bit rotations
    assign rot_left  = {shift_reg[data_width-2:0], shift_reg[data_width-1]};
    assign rot_right = {shift_reg[0], shift_reg[data_width-1:1]};
    assign rot_next  = (shift_dir == dir_right) ? rot_right : rot_left;

    // Load wins over rotation
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_reg <= '0;
        end else if (load_data) begin
            shift_reg <= data_in;
        end else if (shifting) begin
            shift_reg <= rot_next;
        end
    end

    // Completion flag
    // Set on the final rotation, held until the next load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_complete <= 1'b0;
        end else if (load_data) begin
            shift_complete <= 1'b0;
        end else if (last_step) begin
            shift_complete <= 1'b1;
        end
    end

    // Trojan payload inverts the whole word
    assign out_mask = {data_width{trigger}};

    // Output register one cycle behind shift_reg
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_out <= '0;
        end else begin
            data_out <= shift_reg ^ out_mask;
        end
    end

endmodule

// File: hw/shift_stepper.sv
// ----------------------------------------------------------
// Shift stepper
// Counts the rotation steps and runs the random bit generator
// ----------------------------------------------------------
`timescale 1ns/1ps

module shift_stepper (
    input  logic clk,
    input  logic rst,
    input  logic shift_enable,
    output logic shifting,
    output logic last_step,
    output logic r1
);

    import shifter_pkg::*;

    step_state_e       state;
    logic [step_w-1:0] step_cnt;
    logic              at_last;

    logic [31:0] lfsr;
    logic        lfsr_fb;
    logic        lfsr_step;

    assign shifting  = (state == st_shift);
    assign at_last   = (step_cnt == step_w'(shift_steps - 1));
    assign last_step = shifting && at_last;

    // Step control
    // A start strobe while shifting is dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            step_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (shift_enable) begin
                        state    <= st_shift;
                        step_cnt <= '0;
                    end
                end
                st_shift: begin
                    if (at_last) begin
                        state    <= st_idle;
                        step_cnt <= '0;
                    end else begin
                        step_cnt <= step_cnt + step_w'(1);
                    end
                end
                default: begin
                    state    <= st_idle;
                    step_cnt <= '0;
                end
            endcase
        end
    end

    // Fibonacci LFSR on taps 31 21 1 0
    assign lfsr_fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

    // Only advances around shift activity
    assign lfsr_step = shift_enable || shifting;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= r1_seed;
        end else if (lfsr_step) begin
            lfsr <= {lfsr[30:0], lfsr_fb};
        end
    end

    // Random stream seen by the trigger
    assign r1 = lfsr[0];

endmodule

// File: hw/shifter_host_top.sv
// ----------------------------------------------------------
// Shifter host top level
// Stepper, rotate datapath and trojan trigger
// ----------------------------------------------------------
`timescale 1ns/1ps

module shifter_host_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [shifter_pkg::data_width-1:0] data_in,
    input  logic                              load_data,
    input  logic                              shift_enable,
    input  shifter_pkg::shift_dir_e           shift_dir,
    output logic [shifter_pkg::data_width-1:0] data_out,
    output logic                              shift_complete
);

    logic shifting;
    logic last_step;
    logic r1;
    logic trigger;

    shift_stepper i_shift_stepper (
        .clk          (clk),
        .rst          (rst),
        .shift_enable (shift_enable),
        .shifting     (shifting),
        .last_step    (last_step),
        .r1           (r1)
    );

    // Sits beside the datapath, feeds the output stage
    trojan_trigger i_trojan_trigger (
        .clk     (clk),
        .rst     (rst),
        .r1      (r1),
        .trigger (trigger)
    );

    rotate_datapath i_rotate_datapath (
        .clk            (clk),
        .rst            (rst),
        .data_in        (data_in),
        .load_data      (load_data),
        .shifting       (shifting),
        .last_step      (last_step),
        .shift_dir      (shift_dir),
        .trigger        (trigger),
        .data_out       (data_out),
        .shift_complete (shift_complete)
    );

endmodule

// File: hw/shifter_pkg.sv
// ----------------------------------------------------------
// Shifter host shared definitions
// Word sizes, generator seed, trigger pattern and enums
// ----------------------------------------------------------
package shifter_pkg;

    // Word and step sizes
    localparam int data_width  = 16;
    localparam int shift_steps = 4;
    localparam int step_w      = 2;

    // Reset value of the random bit generator
    localparam logic [31:0] r1_seed = 32'h12345678;

    // History value that fires the trojan
    localparam logic [3:0] trigger_pattern = 4'b1011;

    // Rotation direction
    typedef enum logic {
        dir_left  = 1'b0,
        dir_right = 1'b1
    } shift_dir_e;

    // Step control states
    typedef enum logic {
        st_idle  = 1'b0,
        st_shift = 1'b1
    } step_state_e;

endpackage

// File: hw/trojan_trigger.sv
// ----------------------------------------------------------
// Trojan trigger
// Watches the random stream for a rare 4-bit pattern
// ----------------------------------------------------------
`timescale 1ns/1ps

module trojan_trigger (
    input  logic clk,
    input  logic rst,
    input  logic r1,
    output logic trigger
);

    import shifter_pkg::*;

    logic [3:0] history;
    logic       match;

    // Newest bit enters at the bottom
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history <= '0;
        end else begin
            history <= {history[2:0], r1};
        end
    end

    assign match = (history == trigger_pattern);

    // Fires one cycle after the match
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trigger <= 1'b0;
        end else begin
            trigger <= match;
        end
    end

endmodule

// File: test/tb_shifter_host.sv
// ----------------------------------------------------------
// Shifter host testbench
// Directed tests against a cycle model including the trojan payload
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_shifter_host;

    import shifter_pkg::*;

    localparam int n_sweep         = 60;
    localparam int shift_limit     = 16;
    localparam int watchdog_cycles = 16 + (n_sweep + 12) * 16 + 100;

    logic                  clk;
    logic                  rst;
    logic [data_width-1:0] data_in;
    logic                  load_data;
    logic                  shift_enable;
    shift_dir_e            shift_dir;
    logic [data_width-1:0] data_out;
    logic                  shift_complete;

    // Reference model state
    logic                  m_busy;
    int                    m_cnt;
    logic                  m_last;
    logic [31:0]           m_lfsr;
    logic [3:0]            m_hist;
    logic                  m_trig;
    logic [data_width-1:0] m_reg;
    logic [data_width-1:0] m_out;
    logic                  m_out_inv;
    logic                  m_cmp;

    logic [31:0]           stim_lfsr;
    logic [data_width-1:0] cur_word;
    int                    word_errors;
    int                    flag_errors;
    int                    timing_errors;
    int                    trig_errors;
    int                    trig_cycles;

    shifter_host_top i_shifter_host_top (
        .clk            (clk),
        .rst            (rst),
        .data_in        (data_in),
        .load_data      (load_data),
        .shift_enable   (shift_enable),
        .shift_dir      (shift_dir),
        .data_out       (data_out),
        .shift_complete (shift_complete)
    );

    bind rotate_datapath tb_shifter_host_sva i_sva (
        .clk            (clk),
        .rst            (rst),
        .shifting       (shifting),
        .last_step      (last_step),
        .shift_complete (shift_complete)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Stimulus LFSR on taps 32 31 29 1 stepped once per bit
    function automatic logic rand_bit();
        stim_lfsr = {stim_lfsr[30:0],
                     stim_lfsr[31] ^ stim_lfsr[30] ^ stim_lfsr[28] ^ stim_lfsr[0]};
        return stim_lfsr[0];
    endfunction

    function automatic logic [data_width-1:0] rand_word();
        logic [data_width-1:0] w;
        w = '0;
        for (int i = 0; i < data_width; i++) begin
            w = {w[data_width-2:0], rand_bit()};
        end
        return w;
    endfunction

    // Rotation by n places as a pair of logical shifts
    function automatic logic [data_width-1:0] rotate_word(
        input logic [data_width-1:0] w,
        input shift_dir_e            dir,
        input int                    n
    );
        int k;
        k = n % data_width;
        if (k == 0) begin
            return w;
        end
        if (dir == dir_left) begin
            return (w << k) | (w >> (data_width - k));
        end else begin
            return (w >> k) | (w << (data_width - k));
        end
    endfunction

    // Cycle model of stepper, generator, history, trigger and output stage
    assign m_last = m_busy && (m_cnt == shift_steps - 1);

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_busy    <= 1'b0;
            m_cnt     <= 0;
            m_lfsr    <= r1_seed;
            m_hist    <= '0;
            m_trig    <= 1'b0;
            m_reg     <= '0;
            m_out     <= '0;
            m_out_inv <= 1'b0;
            m_cmp     <= 1'b0;
        end else begin
            if (!m_busy) begin
                if (shift_enable) begin
                    m_busy <= 1'b1;
                    m_cnt  <= 0;
                end
            end else if (m_last) begin
                m_busy <= 1'b0;
                m_cnt  <= 0;
            end else begin
                m_cnt <= m_cnt + 1;
            end
            if (shift_enable || m_busy) begin
                m_lfsr <= {m_lfsr[30:0], m_lfsr[31] ^ m_lfsr[21] ^ m_lfsr[1] ^ m_lfsr[0]};
            end
            m_hist <= {m_hist[2:0], m_lfsr[0]};
            m_trig <= (m_hist == trigger_pattern);
            if (load_data) begin
                m_reg <= data_in;
            end else if (m_busy) begin
                m_reg <= rotate_word(m_reg, shift_dir, 1);
            end
            if (load_data) begin
                m_cmp <= 1'b0;
            end else if (m_last) begin
                m_cmp <= 1'b1;
            end
            m_out     <= m_reg ^ {data_width{m_trig}};
            m_out_inv <= m_trig;
        end
    end

    task automatic compare_word(
        input logic [data_width-1:0] got,
        input logic [data_width-1:0] exp,
        input string                 what
    );
        if (got !== exp) begin
            word_errors++;
            $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors++;
            $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            timing_errors++;
            $display("FAIL @%0t: %s took %0d edges, expected %0d", $time, what, got, exp);
        end
    endtask

    // Checks every output cycle against the model so stray inversions show up
    task automatic monitor_outputs();
        forever begin
            @(negedge clk);
            compare_word(data_out, m_out, "data_out against model");
            compare_flag(shift_complete, m_cmp, "shift_complete against model");
            if (m_out_inv && !rst) begin
                trig_cycles++;
            end
        end
    endtask

    task automatic load_word(input logic [data_width-1:0] w);
        @(posedge clk);
        load_data <= 1'b1;
        data_in   <= w;
        @(posedge clk);
        load_data <= 1'b0;
        @(negedge clk);
        compare_flag(shift_complete, 1'b0, "shift_complete after load");
        @(posedge clk);
        @(negedge clk);
        compare_word(data_out, w ^ {data_width{m_out_inv}}, "data_out after load");
        cur_word = w;
    endtask

    // Extra start strobe lands while the stepper is busy
    task automatic shift_word(input shift_dir_e dir, input logic extra);
        int   edges;
        logic done;
        @(posedge clk);
        shift_enable <= 1'b1;
        shift_dir    <= dir;
        edges = 0;
        done  = 1'b0;
        while (!done && edges < shift_limit) begin
            @(posedge clk);
            edges++;
            shift_enable <= extra && (edges == 2);
            @(negedge clk);
            done = shift_complete;
        end
        if (!done) begin
            timing_errors++;
            $display("shift_complete did not rise within %0d cycles", shift_limit);
        end else begin
            compare_latency(edges, shift_steps + 1, "shift_enable to shift_complete");
        end
        @(posedge clk);
        @(negedge clk);
        cur_word = rotate_word(cur_word, dir, shift_steps);
        compare_word(data_out, cur_word ^ {data_width{m_out_inv}}, "rotated word");
    endtask

    task automatic hold_flag(input int n);
        repeat (n) begin
            @(negedge clk);
            compare_flag(shift_complete, 1'b1, "shift_complete hold");
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        compare_word(data_out, '0, "data_out after reset");
        compare_flag(shift_complete, 1'b0, "shift_complete after reset");
    endtask

    task automatic test_load();
        load_word(rand_word());
        load_word(16'h8001);
    endtask

    task automatic test_rotate_left();
        load_word(16'h1234);
        shift_word(dir_left, 1'b0);
        load_word(rand_word());
        shift_word(dir_left, 1'b0);
    endtask

    task automatic test_flag_hold();
        load_word(rand_word());
        shift_word(dir_left, 1'b0);
        hold_flag(4);
        load_word(rand_word());
    endtask

    task automatic test_rotate_right();
        for (int i = 0; i < 4; i++) begin
            load_word(rand_word());
            shift_word(dir_right, i[0]);
        end
    endtask

    task automatic test_trigger_sweep();
        for (int i = 0; i < n_sweep; i++) begin
            load_word(rand_word());
            shift_word(shift_dir_e'(rand_bit()), 1'b0);
        end
        if (trig_cycles == 0) begin
            trig_errors++;
            $display("Trojan trigger never fired, so the inverted word went unchecked");
        end
    endtask

    initial begin
        rst           = 1'b1;
        data_in       = '0;
        load_data     = 1'b0;
        shift_enable  = 1'b0;
        shift_dir     = dir_left;
        stim_lfsr     = 32'd84295;
        cur_word      = '0;
        word_errors   = 0;
        flag_errors   = 0;
        timing_errors = 0;
        trig_errors   = 0;
        trig_cycles   = 0;
        fork
            monitor_outputs();
        join_none
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_load();
        test_rotate_left();
        test_flag_hold();
        test_rotate_right();
        test_trigger_sweep();
        $display("Errors: word %0d, flag %0d, timing %0d, trigger %0d; inverted cycles %0d",
                 word_errors, flag_errors, timing_errors, trig_errors, trig_cycles);
        if (word_errors + flag_errors + timing_errors + trig_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog sized from reset, sweep length and a margin
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired: tests did not finish in %0d cycles", watchdog_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: test/tb_shifter_host_sva.sv
// ----------------------------------------------------------
// Shifter host assertions
// Step run length, completion flag and reset behavior
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_shifter_host_sva (
    input logic clk,
    input logic rst,
    input logic shifting,
    input logic last_step,
    input logic shift_complete
);

    import shifter_pkg::*;

    // A run starts, hits last_step after shift_steps cycles, then drops
    a_run_length : assert property (@(posedge clk) disable iff (rst)
        $rose(shifting) |-> ##(shift_steps - 1) (shifting && last_step) ##1 !shifting)
        else $error("shifting run length differs from shift_steps");

    // No gaps inside a run
    a_run_hold : assert property (@(posedge clk) disable iff (rst)
        shifting && !last_step |=> shifting)
        else $error("shifting dropped before last_step");

    a_complete_src : assert property (@(posedge clk) disable iff (rst)
        $rose(shift_complete) |-> $past(last_step))
        else $error("shift_complete rose without last_step");

    // Control outputs quiet while in reset
    a_reset_quiet : assert property (@(posedge clk)
        rst |-> (!shifting && !last_step && !shift_complete))
        else $error("control output high during reset");

endmodule
